/* build.f */
source/vid_pkg.sv
source/cmos_pixel_pack.sv
source/frame_ctrl_fsm.sv
source/frame_store.sv
source/video_timing.sv
source/cam_display_top.sv
dv/tb_cam_display.sv

/* dv/tb_cam_display.sv */
`timescale 1ns/1ns

module tb_cam_display import vid_pkg::*;
();

    logic              core_clk;
    logic              i_arst_n;
    logic              i_cam_vsync;
    logic              i_cam_href;
    logic [7:0]        i_cam_data;
    logic              o_hs;
    logic              o_vs;
    logic              o_de;
    chan8_t            o_r;
    chan8_t            o_g;
    chan8_t            o_b;
    logic              o_display_en;

    logic [15:0]       sent_words [FRAME_PIXELS];           // bytes as sent, paired
    rgb565_t           model      [FRAME_PIXELS];           // what the display must show
    logic [ADDR_W-1:0] rd_idx;
    bit                model_ready;
    bit                pre_full;                            // no complete frame sent yet
    bit                check_en;
    bit                pre_prev;
    bit                de_prev;
    bit                hs_prev;
    bit                vs_prev;
    bit                en_prev;
    bit                en_wait;
    bit                hs_seen;
    int                pix_cnt;
    int                line_cnt;
    int                hs_len;
    int                vs_len;
    int                cyc;
    int                last_hs_rise;
    int                en_cnt;
    int                early_en;
    int                early_de;
    int                early_hs;
    int                early_vs;
    int                frames_checked;
    int                mismatch_errs;
    int                timeout_errs;

    cam_display_top cam_display_top_i (
        .core_clk     (core_clk),
        .i_arst_n     (i_arst_n),
        .i_cam_vsync  (i_cam_vsync),
        .i_cam_href   (i_cam_href),
        .i_cam_data   (i_cam_data),
        .o_hs         (o_hs),
        .o_vs         (o_vs),
        .o_de         (o_de),
        .o_r          (o_r),
        .o_g          (o_g),
        .o_b          (o_b),
        .o_display_en (o_display_en)
    );

    initial
    begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_pixel(input int x, input int y,
                               input chan8_t exp_r, input chan8_t exp_g, input chan8_t exp_b,
                               input chan8_t act_r, input chan8_t act_g, input chan8_t act_b);
    begin
        if (act_r !== exp_r)
        begin
            $display("Mismatch o_r at pixel %0d line %0d: expected %h, got %h", x, y, exp_r, act_r);
            mismatch_errs++;
        end
        if (act_g !== exp_g)
        begin
            $display("Mismatch o_g at pixel %0d line %0d: expected %h, got %h", x, y, exp_g, act_g);
            mismatch_errs++;
        end
        if (act_b !== exp_b)
        begin
            $display("Mismatch o_b at pixel %0d line %0d: expected %h, got %h", x, y, exp_b, act_b);
            mismatch_errs++;
        end
    end
    endtask

    task automatic check_count(input string name, input int act, input int exp);
    begin
        if (act != exp)
        begin
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
            mismatch_errs++;
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // camera side

    task automatic drive_cam(input logic vs, input logic hr, input logic [7:0] d);
    begin
        @(posedge core_clk);
        i_cam_vsync <= vs;
        i_cam_href  <= hr;
        i_cam_data  <= d;
    end
    endtask

    task automatic send_frame(input int n_lines);
        int          line;
        int          px;
        int          gap;
        logic [15:0] w;
    begin
        repeat (3) drive_cam(1'b1, 1'b0, 8'h00);            // frame start
        repeat (4) drive_cam(1'b0, 1'b0, 8'h00);
        for (line = 0; line < n_lines; line++)
        begin
            gap = 1 + $urandom_range(4);
            repeat (gap) drive_cam(1'b0, 1'b0, 8'($urandom));
            if (line == 3 || $urandom_range(2) == 0)
            begin
                drive_cam(1'b0, 1'b1, 8'($urandom));        // lone byte, must be dropped
                drive_cam(1'b0, 1'b0, 8'($urandom));
            end
            for (px = 0; px < H_ACTIVE; px++)
            begin
                w = 16'($urandom);
                sent_words[ADDR_W'(line * H_ACTIVE + px)] = w;
                drive_cam(1'b0, 1'b1, w[15:8]);             // high byte first
                drive_cam(1'b0, 1'b1, w[7:0]);
            end
        end
    end
    endtask

    // red and blue swap places between port and buffer
    task automatic load_model();
        int k;
    begin
        for (k = 0; k < FRAME_PIXELS; k++)
        begin
            model[ADDR_W'(k)].f.r = sent_words[ADDR_W'(k)][4:0];
            model[ADDR_W'(k)].f.g = sent_words[ADDR_W'(k)][10:5];
            model[ADDR_W'(k)].f.b = sent_words[ADDR_W'(k)][15:11];
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bounded waits

    task automatic wait_display_en(input int limit);
        int n;
    begin
        n = 0;
        while (!o_display_en && n < limit)
        begin
            @(negedge core_clk);
            n++;
        end
        if (!o_display_en)
        begin
            $display("Timeout: display was never enabled within %0d cycles", limit);
            timeout_errs++;
        end
    end
    endtask

    task automatic wait_frames(input int target, input int limit);
        int n;
    begin
        n = 0;
        while (frames_checked < target && n < limit)
        begin
            @(negedge core_clk);
            n++;
        end
        if (frames_checked < target)
        begin
            $display("Timeout: only %0d of %0d checked display frames within %0d cycles",
                     frames_checked, target, limit);
            timeout_errs++;
        end
    end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // display monitor, sampled on the falling edge

    always @(negedge core_clk)
    begin
        cyc++;
        if (pre_full)
        begin
            early_en += int'(o_display_en);
            early_de += int'(o_de);
            early_hs += int'(o_hs);
            early_vs += int'(o_vs);
        end
        if (pre_prev && !pre_full)
        begin
            check_count("o_display_en high cycles before full frame", early_en, 0);
            check_count("o_de high cycles before full frame", early_de, 0);
            check_count("o_hs high cycles before full frame", early_hs, 0);
            check_count("o_vs high cycles before full frame", early_vs, 0);
        end
        if (o_display_en && !en_prev)
        begin
            en_wait = 1'b1;
            en_cnt  = 0;
        end
        else if (en_wait)
        begin
            en_cnt++;
            if (o_de)
            begin
                check_count("o_display_en to first o_de cycles", en_cnt, OUT_LAT);
                en_wait = 1'b0;
            end
        end
        if (!model_ready)
            check_en = 1'b0;                                // buffer being rewritten
        if (o_vs && !vs_prev)
        begin
            check_count("o_de lines per frame", line_cnt, V_ACTIVE);
            if (check_en)
                frames_checked++;
            line_cnt = 0;
            vs_len   = 0;
        end
        if (o_vs)
            vs_len++;
        if (!o_vs && vs_prev)
            check_count("o_vs width", vs_len, V_SYNC * H_TOTAL);
        if (o_hs && !hs_prev)
        begin
            if (hs_seen)
                check_count("o_hs period", cyc - last_hs_rise, H_TOTAL);
            hs_seen      = 1'b1;
            last_hs_rise = cyc;
            hs_len       = 0;
        end
        if (o_hs)
            hs_len++;
        if (!o_hs && hs_prev)
            check_count("o_hs width", hs_len, H_SYNC);
        if (o_de)
        begin
            if (!de_prev && line_cnt == 0)
                check_en = model_ready;                     // new display frame
            if (check_en && pix_cnt < H_ACTIVE && line_cnt < V_ACTIVE)
            begin
                rd_idx = ADDR_W'(line_cnt * H_ACTIVE + pix_cnt);
                check_pixel(pix_cnt, line_cnt,
                            {model[rd_idx].f.r, 3'b000}, {model[rd_idx].f.g, 2'b00},
                            {model[rd_idx].f.b, 3'b000}, o_r, o_g, o_b);
            end
            pix_cnt++;
        end
        else if (de_prev)
        begin
            check_count("o_de cycles per line", pix_cnt, H_ACTIVE);
            line_cnt++;
            pix_cnt = 0;
        end
        pre_prev = pre_full;
        de_prev  = o_de;
        hs_prev  = o_hs;
        vs_prev  = o_vs;
        en_prev  = o_display_en;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial
    begin
        void'($urandom(32'h7846_b662));
        i_arst_n    <= 1'b0;
        i_cam_vsync <= 1'b0;
        i_cam_href  <= 1'b0;
        i_cam_data  <= 8'h00;
        repeat (5) @(posedge core_clk);
        i_arst_n <= 1'b1;
        repeat (4) drive_cam(1'b0, 1'b0, 8'h00);

        pre_full = 1'b1;                                    // partial frame, display stays dark
        send_frame(5);
        repeat (40) drive_cam(1'b0, 1'b0, 8'h00);
        pre_full = 1'b0;

        send_frame(V_ACTIVE);
        repeat (3) drive_cam(1'b0, 1'b0, 8'h00);            // last pixel now stored
        load_model();
        model_ready = 1'b1;
        wait_display_en(64);
        wait_frames(frames_checked + 2, 4 * V_TOTAL * H_TOTAL);

        drive_cam(1'b0, 1'b0, 8'h00);
        model_ready = 1'b0;                                 // second frame overwrites the buffer
        send_frame(V_ACTIVE);
        repeat (3) drive_cam(1'b0, 1'b0, 8'h00);
        load_model();
        model_ready = 1'b1;
        wait_frames(frames_checked + 2, 4 * V_TOTAL * H_TOTAL);
        repeat (4) drive_cam(1'b0, 1'b0, 8'h00);

        $display("errors: mismatch=%0d timeout=%0d checked_frames=%0d",
                 mismatch_errs, timeout_errs, frames_checked);
        if (mismatch_errs == 0 && timeout_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tb_cam_display \
    -o sim_cam_display

out=$(./obj_dir/sim_cam_display)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

/* source/cam_display_top.sv */
`timescale 1ns/1ns

module cam_display_top import vid_pkg::*;
(
    input  logic       core_clk,
    input  logic       i_arst_n,
    input  logic       i_cam_vsync,
    input  logic       i_cam_href,
    input  logic [7:0] i_cam_data,
    output logic       o_hs,
    output logic       o_vs,
    output logic       o_de,
    output chan8_t     o_r,
    output chan8_t     o_g,
    output chan8_t     o_b,
    output logic       o_display_en
);

    logic              pix_valid;
    rgb565_t           pix;
    logic              sof;
    logic              wr_restart;
    logic              wr_allow;
    logic              wr_full;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;

    ////////////////////////////////////////////////////////////////////////////
    // camera capture and frame control

    cmos_pixel_pack cmos_pixel_pack_i (
        .core_clk     (core_clk),
        .i_arst_n     (i_arst_n),
        .i_cam_vsync  (i_cam_vsync),
        .i_cam_href   (i_cam_href),
        .i_cam_data   (i_cam_data),
        .o_pix_valid  (pix_valid),
        .o_pix        (pix),
        .o_sof        (sof)
    );

    frame_ctrl_fsm frame_ctrl_fsm_i (
        .core_clk     (core_clk),
        .i_arst_n     (i_arst_n),
        .i_sof        (sof),
        .i_wr_full    (wr_full),
        .o_wr_restart (wr_restart),
        .o_wr_allow   (wr_allow),
        .o_display_en (o_display_en)
    );

    ////////////////////////////////////////////////////////////////////////////
    // buffer and display raster

    frame_store frame_store_i (
        .core_clk     (core_clk),
        .i_arst_n     (i_arst_n),
        .i_wr_restart (wr_restart),
        .i_wr_allow   (wr_allow),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .i_rd_en      (rd_en),
        .i_rd_addr    (rd_addr),
        .o_wr_full    (wr_full),
        .o_r          (o_r),
        .o_g          (o_g),
        .o_b          (o_b)
    );

    video_timing video_timing_i (
        .core_clk     (core_clk),
        .i_arst_n     (i_arst_n),
        .i_display_en (o_display_en),
        .o_rd_en      (rd_en),
        .o_rd_addr    (rd_addr),
        .o_hs         (o_hs),
        .o_vs         (o_vs),
        .o_de         (o_de)
    );

endmodule

/* source/cmos_pixel_pack.sv */
`timescale 1ns/1ns

module cmos_pixel_pack import vid_pkg::*;
(
    input  logic        core_clk,
    input  logic        i_arst_n,
    input  logic        i_cam_vsync,
    input  logic        i_cam_href,
    input  logic [7:0]  i_cam_data,
    output logic        o_pix_valid,
    output rgb565_t     o_pix,
    output logic        o_sof
);

    logic       vsync_d0;
    logic       vsync_d1;
    logic       href_d0;
    logic [7:0] data_d0;
    logic       phase;                                      // 1 = high byte held
    logic [7:0] byte_hi;
    rgb565_t    pair_word;

    ////////////////////////////////////////////////////////////////////////////
    // input register and byte pairing

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            vsync_d0    <= 1'b0;
            vsync_d1    <= 1'b0;
            href_d0     <= 1'b0;
            phase       <= 1'b0;
            o_pix_valid <= 1'b0;
            o_sof       <= 1'b0;
        end
        else
        begin
            vsync_d0    <= i_cam_vsync;
            vsync_d1    <= vsync_d0;
            href_d0     <= i_cam_href;
            phase       <= href_d0 ? ~phase : 1'b0;         // odd leftover byte dropped
            o_pix_valid <= href_d0 & phase;
            o_sof       <= vsync_d0 & ~vsync_d1;            // vsync rising edge
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_d0 <= i_cam_data;
        if (href_d0 && !phase)
            byte_hi <= data_d0;                             // first byte goes high
    end

    assign pair_word.raw = {byte_hi, data_d0};

    // red and blue trade places on the way out
    always_ff @(posedge core_clk)
    begin
        if (href_d0 && phase)
        begin
            o_pix.f.r <= pair_word.f.b;
            o_pix.f.g <= pair_word.f.g;
            o_pix.f.b <= pair_word.f.r;
        end
    end

    a_pix_spaced: assert property (@(posedge core_clk) disable iff (!i_arst_n)
        o_pix_valid |=> !o_pix_valid);

endmodule

/* source/frame_ctrl_fsm.sv */
`timescale 1ns/1ns

module frame_ctrl_fsm import vid_pkg::*;
(
    input  logic core_clk,
    input  logic i_arst_n,
    input  logic i_sof,
    input  logic i_wr_full,
    output logic o_wr_restart,
    output logic o_wr_allow,
    output logic o_display_en
);

    logic [ST_W-1:0] state;
    logic [ST_W-1:0] state_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // state register

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= ST_WAIT_SOF;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_WAIT_SOF:
            begin
                if (i_sof)
                    state_nxt = ST_FILL;                    // first frame begins
            end
            ST_FILL:
            begin
                if (i_wr_full)
                    state_nxt = ST_RUN;                     // buffer holds a whole frame
            end
            ST_RUN:
            begin
                state_nxt = ST_RUN;                         // only reset leaves
            end
            default:
            begin
                state_nxt = ST_WAIT_SOF;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs

    // every frame start rewinds the writer, including the one that leaves WAIT_SOF
    assign o_wr_restart = i_sof;
    assign o_wr_allow   = (state == ST_FILL) || (state == ST_RUN);
    assign o_display_en = (state == ST_RUN);

    a_display_sticky: assert property (@(posedge core_clk) disable iff (!i_arst_n)
        o_display_en |=> o_display_en);

endmodule

/* source/frame_store.sv */
`timescale 1ns/1ns

module frame_store import vid_pkg::*;
(
    input  logic              core_clk,
    input  logic              i_arst_n,
    input  logic              i_wr_restart,
    input  logic              i_wr_allow,
    input  logic              i_pix_valid,
    input  rgb565_t           i_pix,
    input  logic              i_rd_en,
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic              o_wr_full,
    output chan8_t            o_r,
    output chan8_t            o_g,
    output chan8_t            o_b
);

    logic [15:0]       mem [FRAME_PIXELS];
    logic [ADDR_W-1:0] wr_addr;
    logic              wr_done;                             // address saturated
    logic              wr_en;
    rgb565_t           rd_word;
    logic              rd_valid;

    ////////////////////////////////////////////////////////////////////////////
    // write side

    assign wr_en     = i_wr_allow & i_pix_valid & ~wr_done;
    assign o_wr_full = wr_en && (wr_addr == ADDR_W'(FRAME_PIXELS - 1));

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_addr <= '0;
            wr_done <= 1'b0;
        end
        else if (i_wr_restart)
        begin
            wr_addr <= '0;
            wr_done <= 1'b0;
        end
        else if (o_wr_full)
            wr_done <= 1'b1;                                // last pixel, address holds
        else if (wr_en)
            wr_addr <= wr_addr + 1'b1;
    end

    always_ff @(posedge core_clk)
    begin
        if (wr_en)
            mem[wr_addr] <= i_pix.raw;
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side, two register stages

    always_ff @(posedge core_clk)
    begin
        if (i_rd_en)
            rd_word.raw <= mem[i_rd_addr];
    end

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            rd_valid <= 1'b0;
            o_r      <= '0;
            o_g      <= '0;
            o_b      <= '0;
        end
        else
        begin
            rd_valid <= i_rd_en;
            o_r      <= rd_valid ? {rd_word.f.r, 3'b000} : '0;  // zero pad low bits
            o_g      <= rd_valid ? {rd_word.f.g, 2'b00}  : '0;
            o_b      <= rd_valid ? {rd_word.f.b, 3'b000} : '0;
        end
    end

    a_no_write_when_full: assert property (@(posedge core_clk) disable iff (!i_arst_n)
        o_wr_full |=> (!wr_en until i_wr_restart));

endmodule

/* source/vid_pkg.sv */
package vid_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry

    localparam int H_ACTIVE     = 16;                       // visible pixels per line
    localparam int V_ACTIVE     = 8;                        // visible lines per frame
    localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;      // buffer depth
    localparam int ADDR_W       = $clog2(FRAME_PIXELS);     // buffer address width

    ////////////////////////////////////////////////////////////////////////////
    // raster timing

    localparam int H_FP    = 2;                             // pixels
    localparam int H_SYNC  = 3;
    localparam int H_BP    = 3;
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;

    localparam int V_FP    = 1;                             // lines
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 1;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam int H_CNT_W = $clog2(H_TOTAL);               // pixel counter width
    localparam int V_CNT_W = $clog2(V_TOTAL);               // line counter width

    localparam int OUT_LAT = 2;                             // read request to colour

    // frame control state codes
    localparam int               ST_W        = 2;
    localparam logic [ST_W-1:0]  ST_WAIT_SOF = 2'd0;        // no frame start seen yet
    localparam logic [ST_W-1:0]  ST_FILL     = 2'd1;        // first frame going in
    localparam logic [ST_W-1:0]  ST_RUN      = 2'd2;        // display live

    // one 16-bit pixel word, seen raw or by colour field
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } f;
    } rgb565_t;

    typedef logic [7:0] chan8_t;                            // one output colour channel

endpackage

/* source/video_timing.sv */
`timescale 1ns/1ns

module video_timing import vid_pkg::*;
(
    input  logic              core_clk,
    input  logic              i_arst_n,
    input  logic              i_display_en,
    output logic              o_rd_en,
    output logic [ADDR_W-1:0] o_rd_addr,
    output logic              o_hs,
    output logic              o_vs,
    output logic              o_de
);

    logic [H_CNT_W-1:0] h_cnt;                              // pixel in line
    logic [V_CNT_W-1:0] v_cnt;                              // line in frame
    logic               h_last;
    logic               v_last;
    logic               de_raw;
    logic               hs_raw;
    logic               vs_raw;
    logic [OUT_LAT-1:0] de_dly;
    logic [OUT_LAT-1:0] hs_dly;
    logic [OUT_LAT-1:0] vs_dly;

    ////////////////////////////////////////////////////////////////////////////
    // raster counters

    assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (!i_display_en)
        begin
            h_cnt <= '0;                                    // parked at origin
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    // active region and sync windows
    assign de_raw = i_display_en && (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hs_raw = (h_cnt >= H_ACTIVE + H_FP) && (h_cnt < H_ACTIVE + H_FP + H_SYNC);
    assign vs_raw = (v_cnt >= V_ACTIVE + V_FP) && (v_cnt < V_ACTIVE + V_FP + V_SYNC);

    assign o_rd_en   = de_raw;
    assign o_rd_addr = ADDR_W'(int'(v_cnt) * H_ACTIVE + int'(h_cnt));

    ////////////////////////////////////////////////////////////////////////////
    // sync delay line, matches the frame store read path

    always_ff @(posedge core_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            de_dly <= '0;
            hs_dly <= '0;
            vs_dly <= '0;
        end
        else
        begin
            de_dly <= {de_dly[OUT_LAT-2:0], de_raw};
            hs_dly <= {hs_dly[OUT_LAT-2:0], hs_raw};
            vs_dly <= {vs_dly[OUT_LAT-2:0], vs_raw};
        end
    end

    assign o_de = de_dly[OUT_LAT-1];
    assign o_hs = hs_dly[OUT_LAT-1];
    assign o_vs = vs_dly[OUT_LAT-1];

    // hs sits in the horizontal blanking, never over active video
    a_de_hs_apart: assert property (@(posedge core_clk) disable iff (!i_arst_n)
        !(o_de && o_hs));

endmodule
